/* flist.f */
+incdir+verilog
verilog/ln_pkg.sv
verilog/ln_ctrl.sv
verilog/ln_mem_sched.sv
verilog/ln_lane.sv
verilog/ln_top.sv
sim/tb_ln_mem.sv
sim/tb_ln_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ln_top -f flist.f -o tb_ln_top
./obj_dir/tb_ln_top | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "run.sh: simulation passed"
    exit 0
else
    echo "run.sh: simulation failed"
    exit 1
fi

/* sim/tb_ln_mem.sv */
`timescale 1ns/1ps
`include "ln_macros.svh"

module tb_ln_mem #(
    parameter int LOG_DEPTH = 256
) (
    input  logic                  core_clk,
    input  logic                  rst_n,
    input  ln_pkg::ln_lbuf_req_t  lbuf_req,
    input  logic [`LN_WORD_W-1:0] lbuf_wdata,
    output logic [`LN_WORD_W-1:0] lbuf_rdata,
    input  ln_pkg::ln_cache_req_t cache_req,
    input  logic [`LN_WORD_W-1:0] cache_wdata,
    output logic [`LN_WORD_W-1:0] cache_rdata
);

    localparam int LBUF_DEPTH  = 1 << `LN_ADDR_W;
    localparam int CACHE_DEPTH = 1 << `LN_CACHE_AW;

    logic [`LN_WORD_W-1:0] lbuf_mem   [0:LBUF_DEPTH-1];
    logic [`LN_WORD_W-1:0] cache_mem  [0:CACHE_DEPTH-1];
    logic [`LN_WORD_W-1:0] lbuf_pipe  [0:`LN_RLAT-1];    // read data in flight
    logic [`LN_WORD_W-1:0] cache_pipe [0:`LN_CRLAT-1];

    // every lbuf write in order of arrival
    logic [`LN_ADDR_W-1:0] log_addr [0:LOG_DEPTH-1];
    logic [`LN_WORD_W-1:0] log_data [0:LOG_DEPTH-1];
    int                    log_cnt;

    task automatic load_word(input int addr, input logic [`LN_WORD_W-1:0] data);
        lbuf_mem[addr] = data;
    endtask

    ////////////////////////////////////////
    // storage with separate lbuf ports
    ////////////////////////////////////////

    always @(posedge core_clk) begin
        if (lbuf_req.wen)
            lbuf_mem[lbuf_req.waddr] <= lbuf_wdata;
        if (cache_req.wen)
            cache_mem[cache_req.addr] <= cache_wdata;   // single port
    end

    ////////////////////////////////////////
    // fixed latency read pipes and log
    ////////////////////////////////////////

    always @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LN_RLAT; i++)
                lbuf_pipe[i] <= '0;
            for (int i = 0; i < `LN_CRLAT; i++)
                cache_pipe[i] <= '0;
            log_cnt <= 0;
        end else begin
            if (lbuf_req.ren)
                lbuf_pipe[0] <= lbuf_mem[lbuf_req.raddr];
            if (cache_req.ren)
                cache_pipe[0] <= cache_mem[cache_req.addr];
            for (int i = 1; i < `LN_RLAT; i++)
                lbuf_pipe[i] <= lbuf_pipe[i-1];
            for (int i = 1; i < `LN_CRLAT; i++)
                cache_pipe[i] <= cache_pipe[i-1];
            if (lbuf_req.wen) begin
                if (log_cnt < LOG_DEPTH) begin
                    log_addr[log_cnt] <= lbuf_req.waddr;
                    log_data[log_cnt] <= lbuf_wdata;
                end
                log_cnt <= log_cnt + 1;   // keeps counting past a full log
            end
        end
    end

    assign lbuf_rdata  = lbuf_pipe[`LN_RLAT-1];
    assign cache_rdata = cache_pipe[`LN_CRLAT-1];

endmodule

/* sim/tb_ln_top.sv */
`timescale 1ns/1ps
`include "ln_macros.svh"

module tb_ln_top;

    localparam int WORDS     = 1 << `LN_ADDR_W;
    localparam int ELEMS     = `LN_LANES * `LN_SLOTS;
    localparam int DW        = `LN_DATA_W;
    localparam int LOG_DEPTH = 256;
    localparam int TIMEOUT   = 5000;      // cycles per wait loop

    logic                  core_clk;
    logic                  rst_n;
    logic                  ln_start;
    ln_pkg::ln_cfg_t       cfg;
    logic [`LN_WORD_W-1:0] lbuf_rdata;
    logic [`LN_WORD_W-1:0] cache_rdata;
    logic                  ln_end;
    ln_pkg::ln_lbuf_req_t  lbuf_req;
    logic [`LN_WORD_W-1:0] lbuf_wdata;
    ln_pkg::ln_cache_req_t cache_req;
    logic [`LN_WORD_W-1:0] cache_wdata;

    logic [`LN_WORD_W-1:0] img [0:WORDS-1];   // lbuf contents before any job
    int                    seed = 32'h13f1_f333;
    int                    err_val;
    int                    err_other;
    int                    checked;           // log entries compared so far
    int                    exp_idx;           // next write of the current job
    bit                    hung;

    ln_top dut (
        .core_clk    (core_clk),
        .rst_n       (rst_n),
        .ln_start    (ln_start),
        .cfg         (cfg),
        .lbuf_rdata  (lbuf_rdata),
        .cache_rdata (cache_rdata),
        .ln_end      (ln_end),
        .lbuf_req    (lbuf_req),
        .lbuf_wdata  (lbuf_wdata),
        .cache_req   (cache_req),
        .cache_wdata (cache_wdata)
    );

    tb_ln_mem #(.LOG_DEPTH(LOG_DEPTH)) mem (
        .core_clk    (core_clk),
        .rst_n       (rst_n),
        .lbuf_req    (lbuf_req),
        .lbuf_wdata  (lbuf_wdata),
        .lbuf_rdata  (lbuf_rdata),
        .cache_req   (cache_req),
        .cache_wdata (cache_wdata),
        .cache_rdata (cache_rdata)
    );

    initial begin
        core_clk = 1'b0;
        forever #20 core_clk = ~core_clk;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // element k of channel ch in block blk after centering
    function automatic logic [DW-1:0] ref_ln(input int blk, input int ch, input int k);
        int                   rbase;
        int                   lane;
        longint               sum;
        longint               mean;
        longint               diff;
        logic signed [DW-1:0] v;
        logic [DW-1:0]        res;
        rbase = (int'(cfg.im_base) + blk * int'(cfg.ifm_align)) % WORDS;
        lane  = k / `LN_SLOTS;
        sum   = 0;
        for (int c = 0; c < int'(cfg.channel_number); c++) begin
            v   = img[(rbase + c) % WORDS][k*DW +: DW];
            sum = sum + longint'(v);
        end
        mean = (sum * longint'(cfg.div[lane].m)) >>> cfg.div[lane].e;
        v    = img[(rbase + ch) % WORDS][k*DW +: DW];
        diff = (longint'(v) - mean) <<< cfg.shift_out;
        if (diff > 127)
            res = 8'h7f;
        else if (diff < -128)
            res = 8'h80;
        else
            res = diff[DW-1:0];
        return res;
    endfunction

    function automatic ln_pkg::ln_div_t div_pair(input int m, input int e);
        ln_pkg::ln_div_t d;
        d.m = 7'(m);
        d.e = 5'(e);
        return d;
    endfunction

    function automatic bit bus_quiet();
        return !(lbuf_req.ren || lbuf_req.wen || cache_req.ren || cache_req.wen || ln_end);
    endfunction

    ////////////////////////////////////////
    // write checker
    ////////////////////////////////////////

    task automatic check_write(input int idx);
        int                    n;
        int                    blk;
        int                    ch;
        logic [`LN_ADDR_W-1:0] want_addr;
        logic [`LN_WORD_W-1:0] want_data;
        n   = int'(cfg.channel_number);
        blk = exp_idx / n;
        ch  = exp_idx % n;
        exp_idx++;
        assert (blk < int'(cfg.block_count)) else begin
            err_other++;
            $display("lbuf write %0d comes after the last block of the job", idx);
        end
        assert (idx < LOG_DEPTH) else begin
            err_other++;
            $display("lbuf write log is full at write %0d", idx);
        end
        if (blk < int'(cfg.block_count) && idx < LOG_DEPTH) begin
            want_addr = `LN_ADDR_W'(int'(cfg.om_base) + blk * int'(cfg.ofm_align) + ch);
            for (int k = 0; k < ELEMS; k++)
                want_data[k*DW +: DW] = ref_ln(blk, ch, k);
            assert (mem.log_addr[idx] == want_addr) else begin
                err_val++;
                $display("FAIL lbuf_req.waddr expected %h got %h", want_addr, mem.log_addr[idx]);
            end
            assert (mem.log_data[idx] == want_data) else begin
                err_val++;
                $display("FAIL lbuf_wdata expected %h got %h", want_data, mem.log_data[idx]);
            end
        end
    endtask

    always @(negedge core_clk) begin
        while (checked < mem.log_cnt) begin
            check_write(checked);
            checked++;
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic expect_quiet(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge core_clk);
            assert (bus_quiet()) else begin
                err_other++;
                $display("memory enable or ln_end high %s", what);
            end
        end
    endtask

    task automatic put_word(input int addr, input logic [`LN_WORD_W-1:0] data);
        img[addr] = data;
        mem.load_word(addr, data);
    endtask

    task automatic apply_cfg(input int n, input int bc, input int ib, input int ob,
                             input int ia, input int oa, input int sh,
                             input ln_pkg::ln_div_t [`LN_LANES-1:0] dv);
        ln_pkg::ln_cfg_t c;
        c.channel_number = `LN_CH_W'(n);
        c.block_count    = 12'(bc);
        c.im_base        = 16'(ib);
        c.om_base        = 16'(ob);
        c.ifm_align      = 12'(ia);
        c.ofm_align      = 12'(oa);
        c.shift_out      = 4'(sh);
        c.div            = dv;
        @(posedge core_clk);
        cfg <= c;
    endtask

    // poke_at > 0 sends a second start that many cycles into the job
    task automatic run_job(input int poke_at);
        int n;
        int bc;
        int cycles;
        int first_log;
        bit seen_end;
        @(posedge core_clk);
        ln_start <= 1'b1;
        n         = int'(cfg.channel_number);
        bc        = int'(cfg.block_count);
        first_log = mem.log_cnt;
        exp_idx   = 0;
        cycles    = 0;
        seen_end  = 1'b0;
        @(posedge core_clk);                 // dut samples the start here
        ln_start <= 1'b0;
        while (!seen_end && cycles < TIMEOUT) begin
            @(negedge core_clk);
            cycles++;
            if (ln_end) begin
                seen_end = 1'b1;
            end else begin
                @(posedge core_clk);
                ln_start <= (cycles == poke_at);
            end
        end
        assert (seen_end) else begin
            err_other++;
            hung = 1'b1;
            $display("ln_end did not arrive within %0d cycles", TIMEOUT);
        end
        if (seen_end) begin
            assert (cycles == bc * (2 * n + 7) + 1) else begin
                err_other++;
                $display("ln_end came %0d cycles after start, expected %0d",
                         cycles, bc * (2 * n + 7) + 1);
            end
            expect_quiet(2 * n + 10, "after ln_end");
            assert (mem.log_cnt - first_log == bc * n) else begin
                err_other++;
                $display("job made %0d lbuf writes instead of %0d",
                         mem.log_cnt - first_log, bc * n);
            end
        end
    endtask

    task automatic run_tests();
        logic [`LN_WORD_W-1:0] w;
        // one block, different divisor per lane
        apply_cfg(8, 1, 'h0100, 'h0800, 0, 0, 1,
                  {div_pair(16, 7), div_pair(127, 10), div_pair(3, 5), div_pair(1, 3)});
        run_job(0);
        if (hung)
            return;
        // three blocks with stepped bases
        apply_cfg(6, 3, 'h0200, 'h0a00, 'h010, 'h020, 0,
                  {div_pair(85, 9), div_pair(1, 0), div_pair(43, 8), div_pair(11, 6)});
        run_job(0);
        if (hung)
            return;
        // full scale inputs clip after the shift
        for (int a = 'h1000; a < 'h1008; a++) begin
            for (int k = 0; k < ELEMS; k++)
                w[k*DW +: DW] = ((a + k) % 3 == 0) ? 8'h80 : 8'h7f;
            put_word(a, w);
        end
        apply_cfg(4, 2, 'h1000, 'h1400, 4, 8, 3,
                  {div_pair(1, 2), div_pair(5, 4), div_pair(1, 2), div_pair(1, 2)});
        run_job(0);
        if (hung)
            return;
        apply_cfg(8, 1, 'h0300, 'h0c00, 0, 0, 2,
                  {div_pair(9, 6), div_pair(32, 8), div_pair(1, 3), div_pair(64, 9)});
        run_job(3);                          // start again while in SUM
    endtask

    initial begin
        rst_n     = 1'b0;
        ln_start  = 1'b0;
        cfg       = '0;
        err_val   = 0;
        err_other = 0;
        checked   = 0;
        exp_idx   = 0;
        hung      = 1'b0;
        for (int a = 0; a < WORDS; a++) begin
            for (int j = 0; j < `LN_WORD_W / 32; j++)
                img[a][j*32 +: 32] = $random(seed);
            mem.load_word(a, img[a]);
        end
        expect_quiet(8, "during reset");
        @(posedge core_clk);
        rst_n <= 1'b1;
        expect_quiet(4, "right after reset");
        run_tests();
        $display("value errors: %0d, other errors: %0d", err_val, err_other);
        if (err_val == 0 && err_other == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* verilog/ln_ctrl.sv */
`timescale 1ns/1ps
`include "ln_macros.svh"

module ln_ctrl (
    input  logic              core_clk,
    input  logic              rst_n,
    input  logic              ln_start,
    input  ln_pkg::ln_cfg_t   cfg,
    output ln_pkg::ln_phase_t phase,
    output logic              block_done,
    output logic              ln_end
);

    ln_pkg::ln_state_e   state;
    ln_pkg::ln_state_e   state_nxt;
    logic [`LN_CH_W-1:0] cnt;
    logic [`LN_CH_W-1:0] cnt_nxt;
    logic [11:0]         blk_cnt;    // blocks finished in this job
    logic                sum_last;
    logic                div_last;
    logic                out_last;
    logic                job_last;

    ////////////////////////////////////////
    // phase end detection
    ////////////////////////////////////////

    // sum runs N + RLAT cycles, out runs N + CRLAT + 1
    assign sum_last = (state == ln_pkg::SUM) &&
                      (cnt == cfg.channel_number + `LN_CH_W'(`LN_RLAT - 1));
    assign div_last = (state == ln_pkg::DIV) &&
                      (cnt == `LN_CH_W'(`LN_DIV_CYCLES - 1));
    assign out_last = (state == ln_pkg::OUT) &&
                      (cnt == cfg.channel_number + `LN_CH_W'(`LN_CRLAT));
    assign job_last = out_last && (blk_cnt == cfg.block_count - 12'd1);

    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt + `LN_CH_W'(1);
        case (state)
            ln_pkg::IDLE: begin
                cnt_nxt = '0;
                if (ln_start) state_nxt = ln_pkg::SUM;
            end
            ln_pkg::SUM: begin
                if (sum_last) begin
                    state_nxt = ln_pkg::DIV;
                    cnt_nxt   = '0;
                end
            end
            ln_pkg::DIV: begin
                if (div_last) begin
                    state_nxt = ln_pkg::OUT;
                    cnt_nxt   = '0;
                end
            end
            ln_pkg::OUT: begin
                if (out_last) begin
                    state_nxt = job_last ? ln_pkg::IDLE : ln_pkg::SUM;
                    cnt_nxt   = '0;
                end
            end
            default: begin
                state_nxt = ln_pkg::IDLE;
                cnt_nxt   = '0;
            end
        endcase
    end

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ln_pkg::IDLE;
            cnt     <= '0;
            blk_cnt <= '0;
            ln_end  <= 1'b0;
        end else begin
            state  <= state_nxt;
            cnt    <= cnt_nxt;
            ln_end <= job_last;     // lands on first idle cycle
            if (state == ln_pkg::IDLE)
                blk_cnt <= '0;
            else if (out_last)
                blk_cnt <= blk_cnt + 12'd1;
        end
    end

    assign block_done  = out_last;
    assign phase.state = state;
    assign phase.cnt   = cnt;

    a_end_single: assert property (@(posedge core_clk) disable iff (!rst_n)
        ln_end |=> !ln_end);

    // busy only after a start request
    a_idle_hold: assert property (@(posedge core_clk) disable iff (!rst_n)
        (state == ln_pkg::IDLE && !ln_start) |=> (state == ln_pkg::IDLE));

endmodule

/* verilog/ln_lane.sv */
`timescale 1ns/1ps
`include "ln_macros.svh"

module ln_lane (
    input  logic                               core_clk,
    input  logic                               rst_n,
    input  ln_pkg::ln_lane_ctl_t               lane_ctl,
    input  ln_pkg::ln_div_t                    div,
    input  logic [3:0]                         shift_out,
    input  logic [`LN_SLOTS*`LN_DATA_W-1:0]    din,
    output logic [`LN_SLOTS*`LN_DATA_W-1:0]    dout
);

    localparam int PROD_W = `LN_SUM_W + 8;     // sum times 7 bit mantissa
    localparam int SHL_W  = PROD_W + 1 + 15;   // difference after max shift

    localparam logic signed [SHL_W-1:0] SAT_MAX = 127;
    localparam logic signed [SHL_W-1:0] SAT_MIN = -128;

    logic mean_pend;   // second divide stage

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n)
            mean_pend <= 1'b0;
        else
            mean_pend <= lane_ctl.mean_start;
    end

    for (genvar s = 0; s < `LN_SLOTS; s++) begin : g_slot
        logic signed [`LN_DATA_W-1:0] x;
        logic signed [`LN_SUM_W-1:0]  acc;
        logic signed [PROD_W-1:0]     prod;
        logic signed [PROD_W-1:0]     mean;
        logic signed [SHL_W-1:0]      diff_shl;
        logic signed [`LN_DATA_W-1:0] sat;
        logic        [`LN_DATA_W-1:0] q;

        assign x = din[s*`LN_DATA_W +: `LN_DATA_W];

        ////////////////////////////////////////
        // row sum and mean
        ////////////////////////////////////////

        always_ff @(posedge core_clk) begin
            if (lane_ctl.clear)
                acc <= '0;
            else if (lane_ctl.acc_en)
                acc <= acc + x;
        end

        always_ff @(posedge core_clk) begin
            if (lane_ctl.mean_start)
                prod <= acc * $signed({1'b0, div.m});
            if (mean_pend)
                mean <= prod >>> div.e;     // arithmetic, keeps sign
        end

        ////////////////////////////////////////
        // center, shift, clip to int8
        ////////////////////////////////////////

        assign diff_shl = (SHL_W'(x) - SHL_W'(mean)) <<< shift_out;

        always_comb begin
            if (diff_shl > SAT_MAX)
                sat = 8'h7f;
            else if (diff_shl < SAT_MIN)
                sat = 8'h80;
            else
                sat = diff_shl[`LN_DATA_W-1:0];
        end

        always_ff @(posedge core_clk) begin
            if (lane_ctl.out_en)
                q <= sat;
        end

        assign dout[s*`LN_DATA_W +: `LN_DATA_W] = q;
    end

    // din is shared between sum and output phases
    a_src_excl: assert property (@(posedge core_clk) disable iff (!rst_n)
        !(lane_ctl.acc_en && lane_ctl.out_en));

endmodule

/* verilog/ln_macros.svh */
`ifndef LN_MACROS_SVH
`define LN_MACROS_SVH

////////////////////////////////////////
// datapath geometry
////////////////////////////////////////

`define LN_LANES      4                // parallel lanes per word
`define LN_SLOTS      4                // int8 rows per lane
`define LN_DATA_W     8
`define LN_WORD_W     (`LN_LANES * `LN_SLOTS * `LN_DATA_W)

////////////////////////////////////////
// addressing
////////////////////////////////////////

`define LN_ADDR_W     13               // lbuf word address
`define LN_CH_W       12               // channel count, up to 2048
`define LN_CACHE_AW   11

// fixed read latencies of at least 2 cycles
`define LN_RLAT       2
`define LN_CRLAT      2

`define LN_SUM_W      (`LN_DATA_W + 11 + 1)   // 2048 int8 terms plus sign
`define LN_DIV_CYCLES 2                // product, then shift

`endif

/* verilog/ln_mem_sched.sv */
`timescale 1ns/1ps
`include "ln_macros.svh"

module ln_mem_sched (
    input  logic                  core_clk,
    input  logic                  rst_n,
    input  ln_pkg::ln_cfg_t       cfg,
    input  ln_pkg::ln_phase_t     phase,
    input  logic                  ln_start,
    input  logic                  block_done,
    output ln_pkg::ln_lbuf_req_t  lbuf_req,
    output ln_pkg::ln_cache_req_t cache_req,
    output ln_pkg::ln_lane_ctl_t  lane_ctl
);

    logic [`LN_ADDR_W-1:0] rd_base;
    logic [`LN_ADDR_W-1:0] wr_base;
    logic [`LN_RLAT-1:0]   lbuf_ren_sr;    // ren delayed to data arrival
    logic [`LN_CRLAT-1:0]  cache_ren_sr;
    logic                  in_sum;
    logic                  in_out;
    logic                  lbuf_ren;
    logic                  cache_ren;
    logic [`LN_CH_W-1:0]   cwr_idx;
    logic [`LN_CH_W-1:0]   lwr_idx;

    assign in_sum = (phase.state == ln_pkg::SUM);
    assign in_out = (phase.state == ln_pkg::OUT);

    ////////////////////////////////////////
    // block base addresses
    ////////////////////////////////////////

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_base <= '0;
            wr_base <= '0;
        end else if (ln_start && phase.state == ln_pkg::IDLE) begin
            rd_base <= cfg.im_base[`LN_ADDR_W-1:0];
            wr_base <= cfg.om_base[`LN_ADDR_W-1:0];
        end else if (block_done) begin
            rd_base <= rd_base + `LN_ADDR_W'(cfg.ifm_align);
            wr_base <= wr_base + `LN_ADDR_W'(cfg.ofm_align);
        end
    end

    ////////////////////////////////////////
    // memory requests
    ////////////////////////////////////////

    assign lbuf_ren  = in_sum && (phase.cnt < cfg.channel_number);
    assign cache_ren = in_out && (phase.cnt < cfg.channel_number);
    assign cwr_idx   = phase.cnt - `LN_CH_W'(`LN_RLAT);
    assign lwr_idx   = phase.cnt - `LN_CH_W'(`LN_CRLAT + 1);

    assign lbuf_req.ren   = lbuf_ren;
    assign lbuf_req.raddr = rd_base + `LN_ADDR_W'(phase.cnt);
    assign lbuf_req.wen   = in_out && (phase.cnt >= `LN_CH_W'(`LN_CRLAT + 1)) &&
                            (phase.cnt < cfg.channel_number + `LN_CH_W'(`LN_CRLAT + 1));
    assign lbuf_req.waddr = wr_base + `LN_ADDR_W'(lwr_idx);

    // cache written as lbuf data returns
    assign cache_req.ren  = cache_ren;
    assign cache_req.wen  = in_sum && (phase.cnt >= `LN_CH_W'(`LN_RLAT)) &&
                            (phase.cnt < cfg.channel_number + `LN_CH_W'(`LN_RLAT));
    assign cache_req.addr = cache_ren ? phase.cnt[`LN_CACHE_AW-1:0]
                                      : cwr_idx[`LN_CACHE_AW-1:0];

    ////////////////////////////////////////
    // lane strobes
    ////////////////////////////////////////

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            lbuf_ren_sr  <= '0;
            cache_ren_sr <= '0;
        end else begin
            lbuf_ren_sr  <= {lbuf_ren_sr[`LN_RLAT-2:0], lbuf_ren};
            cache_ren_sr <= {cache_ren_sr[`LN_CRLAT-2:0], cache_ren};
        end
    end

    assign lane_ctl.clear      = in_sum && (phase.cnt == '0);
    assign lane_ctl.acc_en     = lbuf_ren_sr[`LN_RLAT-1];
    assign lane_ctl.mean_start = (phase.state == ln_pkg::DIV) && (phase.cnt == '0);
    assign lane_ctl.out_en     = cache_ren_sr[`LN_CRLAT-1];

    a_cache_port: assert property (@(posedge core_clk) disable iff (!rst_n)
        !(cache_req.ren && cache_req.wen));

    a_lbuf_rd_sum: assert property (@(posedge core_clk) disable iff (!rst_n)
        lbuf_req.ren |-> (phase.state == ln_pkg::SUM));

endmodule

/* verilog/ln_pkg.sv */
`include "ln_macros.svh"

package ln_pkg;

    typedef enum logic [1:0] {
        IDLE,
        SUM,   // read lbuf, fill cache, accumulate
        DIV,   // sums to means
        OUT    // center, shift, saturate, write back
    } ln_state_e;

    // mean = (sum * m) >>> e
    typedef struct packed {
        logic [6:0] m;
        logic [4:0] e;
    } ln_div_t;

    typedef struct packed {
        logic [`LN_CH_W-1:0]          channel_number;  // words per block
        logic [15:0]                  im_base;
        logic [15:0]                  om_base;
        logic [11:0]                  ifm_align;       // read stride per block
        logic [11:0]                  ofm_align;
        logic [11:0]                  block_count;
        logic [3:0]                   shift_out;
        ln_div_t [`LN_LANES-1:0]      div;             // one pair per lane
    } ln_cfg_t;

    typedef struct packed {
        ln_state_e           state;
        logic [`LN_CH_W-1:0] cnt;   // cycle within phase
    } ln_phase_t;

    typedef struct packed {
        logic                  ren;
        logic [`LN_ADDR_W-1:0] raddr;
        logic                  wen;
        logic [`LN_ADDR_W-1:0] waddr;
    } ln_lbuf_req_t;

    typedef struct packed {
        logic                    ren;
        logic                    wen;
        logic [`LN_CACHE_AW-1:0] addr;   // shared by read and write
    } ln_cache_req_t;

    typedef struct packed {
        logic clear;
        logic acc_en;
        logic mean_start;
        logic out_en;
    } ln_lane_ctl_t;

endpackage

/* verilog/ln_top.sv */
`timescale 1ns/1ps
`include "ln_macros.svh"

module ln_top (
    input  logic                  core_clk,
    input  logic                  rst_n,
    input  logic                  ln_start,      // single cycle pulse
    input  ln_pkg::ln_cfg_t       cfg,           // stable for the whole job
    input  logic [`LN_WORD_W-1:0] lbuf_rdata,
    input  logic [`LN_WORD_W-1:0] cache_rdata,
    output logic                  ln_end,
    output ln_pkg::ln_lbuf_req_t  lbuf_req,
    output logic [`LN_WORD_W-1:0] lbuf_wdata,
    output ln_pkg::ln_cache_req_t cache_req,
    output logic [`LN_WORD_W-1:0] cache_wdata
);

    localparam int LANE_W = `LN_SLOTS * `LN_DATA_W;

    ln_pkg::ln_phase_t    phase;
    ln_pkg::ln_lane_ctl_t lane_ctl;
    logic                 block_done;
    logic [`LN_WORD_W-1:0] lane_din;

    ln_ctrl u_ctrl (
        .core_clk   (core_clk),
        .rst_n      (rst_n),
        .ln_start   (ln_start),
        .cfg        (cfg),
        .phase      (phase),
        .block_done (block_done),
        .ln_end     (ln_end)
    );

    ln_mem_sched u_sched (
        .core_clk   (core_clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .phase      (phase),
        .ln_start   (ln_start),
        .block_done (block_done),
        .lbuf_req   (lbuf_req),
        .cache_req  (cache_req),
        .lane_ctl   (lane_ctl)
    );

    // lbuf feeds the sums, cache replays it for output
    assign lane_din    = (phase.state == ln_pkg::SUM) ? lbuf_rdata : cache_rdata;
    assign cache_wdata = lbuf_rdata;

    for (genvar i = 0; i < `LN_LANES; i++) begin : g_lane
        ln_lane u_lane (
            .core_clk  (core_clk),
            .rst_n     (rst_n),
            .lane_ctl  (lane_ctl),
            .div       (cfg.div[i]),
            .shift_out (cfg.shift_out),
            .din       (lane_din[i*LANE_W +: LANE_W]),
            .dout      (lbuf_wdata[i*LANE_W +: LANE_W])
        );
    end

endmodule
